//--- Makefile
SRCS := $(filter-out +incdir+%,$(shell cat vlog.f)) rv_config.svh

run: obj_dir/Vtb_rv_core
	./obj_dir/Vtb_rv_core > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Test passed$$" sim.log

obj_dir/Vtb_rv_core: $(SRCS) vlog.f
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tb_rv_core -f vlog.f -o Vtb_rv_core

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- rv_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_config.svh"

module rv_alu (
    input  wire rv_pkg::alu_op_t op,
    input  wire rv_pkg::word_t   a,
    input  wire rv_pkg::word_t   b,
    input  wire logic [2:0]      funct3,
    output rv_pkg::word_t        result,
    output logic                 branch_taken
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt;
    logic       ltu;

    assign shamt = b[4:0];
    assign eq    = (a == b);
    assign lt    = ($signed(a) < $signed(b));
    assign ltu   = (a < b);

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_xor:    result = a ^ b;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt;
            alu_slt:    result = {{(`XLEN-1){1'b0}}, lt};
            alu_sltu:   result = {{(`XLEN-1){1'b0}}, ltu};
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    // branch condition on the same operands
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = eq;   // beq
            3'b001:  branch_taken = !eq;  // bne
            3'b100:  branch_taken = lt;   // blt
            3'b101:  branch_taken = !lt;  // bge
            3'b110:  branch_taken = ltu;  // bltu
            3'b111:  branch_taken = !ltu; // bgeu
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath width
`define XLEN 32

// register file geometry
`define REG_COUNT 32
`define REG_ADDR_W 5

// data ram, word addressed
`define DMEM_WORDS 1024
`define DMEM_ADDR_W 10

// fetch
`define RESET_PC 32'h0000_0000
`define INSTR_BYTES 4

`endif

//--- rv_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_config.svh"

module rv_control (
    input  wire                       clk,
    input  wire                       rst,
    output rv_pkg::word_t             imem_addr,
    input  wire rv_pkg::word_t        imem_data,
    output rv_pkg::word_t             instr,
    input  wire rv_pkg::reg_idx_t     rd,
    input  wire rv_pkg::word_t        imm,
    input  wire rv_pkg::opcode_t      opcode,
    input  wire                       use_imm,
    input  wire                       writes_rd,
    input  wire                       is_branch,
    input  wire                       is_load,
    input  wire                       is_store,
    input  wire                       is_jump,
    input  wire rv_pkg::word_t        rs1_data,
    input  wire rv_pkg::word_t        rs2_data,
    output rv_pkg::word_t             alu_a,
    output rv_pkg::word_t             alu_b,
    input  wire rv_pkg::word_t        alu_result,
    input  wire                       branch_taken,
    output logic                      rf_we,
    output rv_pkg::word_t             rf_wdata,
    output logic                      dmem_we,
    output logic [`DMEM_ADDR_W-1:0]   dmem_addr,
    output rv_pkg::word_t             dmem_wdata,
    input  wire rv_pkg::word_t        dmem_rdata,
    output logic                      retire_valid,
    output rv_pkg::word_t             retire_pc,
    output rv_pkg::reg_idx_t          retire_rd,
    output rv_pkg::word_t             retire_data,
    output rv_pkg::word_t             retire_next_pc
);
    import rv_pkg::*;

    state_t state;
    word_t  pc;
    word_t  ir;
    word_t  result_q;   // alu, link, address or load data
    word_t  next_pc_q;
    word_t  pc_plus4;
    word_t  pc_plus_imm;
    word_t  next_pc_d;

    assign pc_plus4    = pc + word_t'(`INSTR_BYTES);
    assign pc_plus_imm = pc + imm;

    always_comb begin
        if (is_jump && opcode == op_jalr)
            next_pc_d = {alu_result[`XLEN-1:1], 1'b0};
        else if (is_jump || (is_branch && branch_taken))
            next_pc_d = pc_plus_imm;
        else
            next_pc_d = pc_plus4;
    end

    assign imem_addr = pc;
    assign instr     = ir;

    assign alu_a = (opcode == op_auipc) ? pc : rs1_data;
    assign alu_b = use_imm ? imm : rs2_data;

    assign dmem_we    = (state == st_memory) && is_store;
    assign dmem_addr  = result_q[`DMEM_ADDR_W+1:2]; // byte address to word index
    assign dmem_wdata = rs2_data;

    assign rf_we    = (state == st_writeback) && writes_rd && (rd != '0);
    assign rf_wdata = result_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= st_fetch;
            pc           <= `RESET_PC;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= 1'b0;
            case (state)
                st_fetch:   state <= st_execute;
                st_execute: state <= st_memory;
                st_memory:  state <= st_writeback;
                default: begin
                    state        <= st_fetch;
                    pc           <= next_pc_q;
                    retire_valid <= 1'b1; // high through the next fetch
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_fetch: ir <= imem_data;
            st_execute: begin
                result_q  <= is_jump ? pc_plus4 : alu_result;
                next_pc_q <= next_pc_d;
            end
            st_memory: begin
                if (is_load)
                    result_q <= dmem_rdata;
            end
            default: begin
                retire_pc      <= pc;
                retire_rd      <= rf_we ? rd : '0;
                retire_data    <= rf_we ? result_q : '0;
                retire_next_pc <= next_pc_q;
            end
        endcase
    end

    a_state_legal : assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state) && state inside {st_fetch, st_execute, st_memory, st_writeback});

    // a store lands only in the memory slot, then writeback follows
    a_store_slot : assert property (@(posedge clk) disable iff (rst)
        dmem_we |-> state == st_memory ##1 state == st_writeback);

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_config.svh"

module rv_core (
    input  wire                   clk,
    input  wire                   rst,
    output rv_pkg::word_t         imem_addr,
    input  wire rv_pkg::word_t    imem_data,
    output logic                  retire_valid,
    output rv_pkg::word_t         retire_pc,
    output rv_pkg::reg_idx_t      retire_rd,
    output rv_pkg::word_t         retire_data,
    output rv_pkg::word_t         retire_next_pc
);
    import rv_pkg::*;

    word_t    instr;
    reg_idx_t rs1, rs2, rd;
    word_t    imm;
    opcode_t  opcode;
    alu_op_t  alu_op;
    logic     use_imm, writes_rd, is_branch, is_load, is_store, is_jump;
    word_t    rs1_data, rs2_data;
    word_t    alu_a, alu_b, alu_result;
    logic     branch_taken;
    logic     rf_we;
    word_t    rf_wdata;
    logic     dmem_we;
    logic [`DMEM_ADDR_W-1:0] dmem_addr;
    word_t    dmem_wdata, dmem_rdata;

    rv_control u_control (
        .clk(clk), .rst(rst),
        .imem_addr(imem_addr), .imem_data(imem_data), .instr(instr),
        .rd(rd), .imm(imm), .opcode(opcode), .use_imm(use_imm),
        .writes_rd(writes_rd), .is_branch(is_branch), .is_load(is_load),
        .is_store(is_store), .is_jump(is_jump),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_a(alu_a), .alu_b(alu_b), .alu_result(alu_result),
        .branch_taken(branch_taken),
        .rf_we(rf_we), .rf_wdata(rf_wdata),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_data(retire_data), .retire_next_pc(retire_next_pc)
    );

    rv_decoder u_decoder (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .opcode(opcode), .alu_op(alu_op), .use_imm(use_imm),
        .writes_rd(writes_rd), .is_branch(is_branch), .is_load(is_load),
        .is_store(is_store), .is_jump(is_jump)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst(rst),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data),
        .we(rf_we), .waddr(rd), .wdata(rf_wdata)
    );

    rv_alu u_alu (
        .op(alu_op), .a(alu_a), .b(alu_b),
        .funct3(instr[14:12]), // branch condition select
        .result(alu_result), .branch_taken(branch_taken)
    );

    rv_dmem u_dmem (
        .clk(clk), .we(dmem_we), .addr(dmem_addr),
        .wdata(dmem_wdata), .rdata(dmem_rdata)
    );

endmodule

`default_nettype wire

//--- rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decoder (
    input  wire rv_pkg::word_t instr,
    output rv_pkg::reg_idx_t   rs1,
    output rv_pkg::reg_idx_t   rs2,
    output rv_pkg::reg_idx_t   rd,
    output rv_pkg::word_t      imm,
    output rv_pkg::opcode_t    opcode,
    output rv_pkg::alu_op_t    alu_op,
    output logic               use_imm,
    output logic               writes_rd,
    output logic               is_branch,
    output logic               is_load,
    output logic               is_store,
    output logic               is_jump
);
    import rv_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    word_t      i_imm, s_imm, b_imm, j_imm, u_imm;

    assign opcode = opcode_t'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};

    always_comb begin
        imm       = '0;
        alu_op    = alu_add;
        use_imm   = 1'b0;
        writes_rd = 1'b0;
        is_branch = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_jump   = 1'b0;
        legal     = 1'b1;
        case (opcode)
            op_reg, op_imm: begin
                writes_rd = 1'b1;
                use_imm   = (opcode == op_imm);
                imm       = i_imm;
                case (funct3)
                    3'b000:  alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
                // funct7 only matters for r-type and immediate shifts
                if (opcode == op_reg || funct3 == 3'b001 || funct3 == 3'b101) begin
                    if (funct3 == 3'b000 || funct3 == 3'b101)
                        legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    else
                        legal = (funct7 == 7'b0000000);
                end
            end
            op_load: begin
                {writes_rd, is_load, use_imm} = 3'b111;
                imm   = i_imm;
                legal = (funct3 == 3'b010); // lw only
            end
            op_store: begin
                {is_store, use_imm} = 2'b11;
                imm   = s_imm;
                legal = (funct3 == 3'b010); // sw only
            end
            op_branch: begin
                is_branch = 1'b1;
                imm       = b_imm;
                legal     = (funct3[2:1] != 2'b01);
            end
            op_jal: begin
                {writes_rd, is_jump} = 2'b11;
                imm = j_imm;
            end
            op_jalr: begin
                {writes_rd, is_jump, use_imm} = 3'b111;
                imm   = i_imm;
                legal = (funct3 == 3'b000);
            end
            op_lui, op_auipc: begin
                {writes_rd, use_imm} = 2'b11;
                imm    = u_imm;
                alu_op = (opcode == op_lui) ? alu_pass_b : alu_add;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin // retire as a no-op
            writes_rd = 1'b0;
            is_branch = 1'b0;
            is_load   = 1'b0;
            is_store  = 1'b0;
            is_jump   = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rv_dmem.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_config.svh"

module rv_dmem (
    input  wire                          clk,
    input  wire                          we,
    input  wire logic [`DMEM_ADDR_W-1:0] addr,
    input  wire rv_pkg::word_t           wdata,
    output rv_pkg::word_t                rdata
);
    import rv_pkg::*;

    word_t mem [`DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
    end

    assign rdata = mem[addr]; // async read

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    // major opcodes of the kept rv32i subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b // lui
    } alu_op_t;

    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_memory,
        st_writeback
    } state_t;

endpackage

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_config.svh"

module rv_regfile (
    input  wire                     clk,
    input  wire                     rst,
    input  wire rv_pkg::reg_idx_t   raddr1,
    input  wire rv_pkg::reg_idx_t   raddr2,
    output rv_pkg::word_t           rdata1,
    output rv_pkg::word_t           rdata2,
    input  wire                     we,
    input  wire rv_pkg::reg_idx_t   waddr,
    input  wire rv_pkg::word_t      wdata
);
    import rv_pkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1]; // x0 never written
    assign rdata2 = regs[raddr2];

    a_x0_zero : assert property (@(posedge clk) disable iff (rst)
        raddr1 == '0 |-> rdata1 == '0);

endmodule

`default_nettype wire

//--- tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_config.svh"

module tb_rv_core;
    import rv_pkg::*;

    localparam logic [6:0] opc_reg   = 7'b0110011;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam int retire_timeout = 12; // cycles
    localparam int max_retires    = 200;

    logic        clk;
    logic        rst;
    word_t       imem_addr;
    word_t       imem_data;
    logic        retire_valid;
    word_t       retire_pc;
    reg_idx_t    retire_rd;
    word_t       retire_data;
    word_t       retire_next_pc;
    word_t       imem [128];
    logic [7:0]  prog_len;
    word_t       model_regs [`REG_COUNT];
    word_t       model_mem [`DMEM_WORDS];
    logic [31:0] seed;
    logic [31:0] cycle;

    rv_core uut (
        .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_data(retire_data), .retire_next_pc(retire_next_pc)
    );

    always #2 clk = ~clk;

    always @(posedge clk or posedge rst) begin
        if (rst)
            cycle <= '0;
        else
            cycle <= cycle + 32'd1;
    end

    // nop past the end of the program
    assign imem_data = (imem_addr[31:2] < {22'd0, prog_len}) ? imem[imem_addr[8:2]]
                                                             : 32'h0000_0013;

    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
                                     input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t j_type(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic emit(input word_t w);
        imem[prog_len[6:0]] = w;
        prog_len = prog_len + 8'd1;
    endtask

    // taken and not-taken pair, each skipping a filler on success
    task automatic branch_pair(input logic [2:0] f3, input reg_idx_t t1, input reg_idx_t t2,
                               input reg_idx_t n1, input reg_idx_t n2);
        emit(b_type(f3, t1, t2, 13'd8));
        emit(i_type(12'h001, 5'd15, 3'b000, 5'd15, opc_imm));
        emit(b_type(f3, n1, n2, 13'd8));
        emit(i_type(12'h001, 5'd15, 3'b000, 5'd15, opc_imm));
    endtask

    task automatic add_random_alu();
        logic [31:0] r;
        logic [6:0]  f7;
        seed = lcg_next(seed);
        r = seed;
        f7 = (r[31] && (r[30:28] == 3'b000 || r[30:28] == 3'b101)) ? 7'b0100000 : 7'b0000000;
        seed = lcg_next(seed);
        if (r[12])
            emit(r_type(f7, r[17:13], r[22:18], r[30:28], r[27:23]));
        else if (r[30:28] == 3'b001 || r[30:28] == 3'b101)
            emit(i_type({f7, seed[24:20]}, r[22:18], r[30:28], r[27:23], opc_imm));
        else
            emit(i_type(seed[31:20], r[22:18], r[30:28], r[27:23], opc_imm));
    endtask

    task automatic build_program();
        prog_len = '0;
        emit({20'h12345, 5'd1, opc_lui});
        emit(i_type(12'h678, 5'd1, 3'b000, 5'd1, opc_imm));
        emit({20'hfedcb, 5'd2, opc_lui});
        emit(i_type(12'hedd, 5'd2, 3'b000, 5'd2, opc_imm));
        emit(i_type(12'hffb, 5'd0, 3'b000, 5'd3, opc_imm)); // x3 = -5
        emit(i_type(12'h007, 5'd0, 3'b000, 5'd4, opc_imm));
        emit({20'h00001, 5'd5, opc_auipc});
        emit(i_type(12'h005, 5'd1, 3'b000, 5'd0, opc_imm)); // lost in x0
        emit(i_type(12'h100, 5'd0, 3'b000, 5'd10, opc_imm));
        emit(s_type(12'h000, 5'd1, 5'd10));
        emit(s_type(12'h004, 5'd2, 5'd10));
        emit(s_type(12'hffc, 5'd3, 5'd10));
        emit(i_type(12'h004, 5'd10, 3'b010, 5'd11, opc_load));
        emit(i_type(12'h000, 5'd10, 3'b010, 5'd12, opc_load));
        emit(i_type(12'hffc, 5'd10, 3'b010, 5'd13, opc_load));
        emit(s_type(12'h000, 5'd4, 5'd10));
        emit(i_type(12'h000, 5'd10, 3'b010, 5'd14, opc_load));
        branch_pair(3'b000, 5'd1, 5'd12, 5'd1, 5'd2);
        branch_pair(3'b001, 5'd1, 5'd2, 5'd1, 5'd12);
        branch_pair(3'b100, 5'd3, 5'd4, 5'd4, 5'd3);
        branch_pair(3'b101, 5'd4, 5'd3, 5'd3, 5'd4);
        branch_pair(3'b110, 5'd4, 5'd3, 5'd3, 5'd4);
        branch_pair(3'b111, 5'd3, 5'd4, 5'd4, 5'd3);
        emit(j_type(21'd8, 5'd5));
        emit(i_type(12'h001, 5'd15, 3'b000, 5'd15, opc_imm));
        emit({20'h00000, 5'd7, opc_auipc});
        emit(i_type(12'h00d, 5'd7, 3'b000, 5'd6, 7'b1100111)); // odd target, bit 0 dropped
        emit(i_type(12'h001, 5'd15, 3'b000, 5'd15, opc_imm));
        emit(32'h0000_000f); // fence
        emit(i_type(12'h000, 5'd10, 3'b001, 5'd9, opc_load)); // lh
        emit(r_type(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd8)); // mul
        repeat (40) add_random_alu();
        emit(j_type(21'd0, 5'd0)); // end of program
    endtask

    function automatic void rv_step(input word_t pc, input word_t ins, output reg_idx_t exp_rd,
                                    output word_t exp_data, output word_t exp_next);
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a, b, imm_i, imm_b, val, addr;
        logic       wr, taken;
        f3 = ins[14:12];
        f7 = ins[31:25];
        a = model_regs[ins[19:15]];
        b = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        val = '0;
        wr = 1'b0;
        exp_next = pc + 32'd4;
        case (ins[6:0])
            opc_reg, opc_imm: begin
                if (ins[6:0] == opc_imm)
                    b = imm_i;
                wr = (f7 == 7'd0) || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101))
                     || (ins[6:0] == opc_imm && f3 != 3'b001 && f3 != 3'b101);
                case (f3)
                    3'b000: val = (ins[6:0] == opc_reg && f7[5]) ? a - b : a + b;
                    3'b001: val = a << b[4:0];
                    3'b010: val = {31'd0, $signed(a) < $signed(b)};
                    3'b011: val = {31'd0, a < b};
                    3'b100: val = a ^ b;
                    3'b101: begin
                        if (f7[5])
                            val = $signed(a) >>> b[4:0];
                        else
                            val = a >> b[4:0];
                    end
                    3'b110: val = a | b;
                    default: val = a & b;
                endcase
            end
            opc_load: begin
                addr = a + imm_i;
                val = model_mem[addr[11:2]];
                wr = (f3 == 3'b010);
            end
            7'b0100011: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                if (f3 == 3'b010)
                    model_mem[addr[11:2]] = b;
            end
            7'b1100011: begin
                case (f3)
                    3'b000: taken = (a == b);
                    3'b001: taken = (a != b);
                    3'b100: taken = $signed(a) < $signed(b);
                    3'b101: taken = $signed(a) >= $signed(b);
                    3'b110: taken = a < b;
                    3'b111: taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken)
                    exp_next = pc + imm_b;
            end
            7'b1101111: begin
                wr = 1'b1;
                val = pc + 32'd4;
                exp_next = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b1100111: begin
                wr = (f3 == 3'b000);
                val = pc + 32'd4;
                if (wr)
                    exp_next = (a + imm_i) & ~32'd1;
            end
            opc_lui, opc_auipc: begin
                wr = 1'b1;
                val = {ins[31:12], 12'd0} + ((ins[6:0] == opc_auipc) ? pc : 32'd0);
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            model_regs[ins[11:7]] = val;
            exp_rd = ins[11:7];
            exp_data = val;
        end else begin
            exp_rd = '0;
            exp_data = '0;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic wait_retire();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!retire_valid) begin
            if (waited >= retire_timeout) begin
                $display("no retire arrived within %0d cycles", retire_timeout);
                $display("Test failed");
                $fatal(1, "retire timeout");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    initial begin
        word_t       exp_pc, exp_data, exp_next;
        reg_idx_t    exp_rd;
        logic [31:0] exp_cycle;
        logic        done;
        int          count;
        clk = 1'b0;
        rst = 1'b1;
        seed = 32'h5a94;
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = '0;
        build_program();
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        exp_pc = `RESET_PC;
        exp_cycle = 32'd4; // first strobe 4 cycles after reset
        done = 1'b0;
        count = 0;
        while (!done) begin
            wait_retire();
            rv_step(exp_pc, imem[exp_pc[8:2]], exp_rd, exp_data, exp_next);
            check_value("retire_valid cycle", cycle, exp_cycle);
            check_value("retire_pc", retire_pc, exp_pc);
            check_value("retire_rd", {27'd0, retire_rd}, {27'd0, exp_rd});
            check_value("retire_data", retire_data, exp_data);
            check_value("retire_next_pc", retire_next_pc, exp_next);
            check_value("imem_addr", imem_addr, exp_next); // next fetch under way
            done = (exp_pc == {22'd0, prog_len - 8'd1, 2'b00});
            exp_pc = exp_next;
            exp_cycle = exp_cycle + 32'd4;
            count++;
            if (count >= max_retires) begin
                $display("program did not reach its final jump within %0d retires", max_retires);
                $display("Test failed");
                $fatal(1, "runaway program");
            end
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_alu.sv
rv_regfile.sv
rv_control.sv
rv_dmem.sv
rv_core.sv
tb_rv_core.sv
